// File: source/axis_sw_params.svh
`ifndef AXIS_SW_PARAMS_SVH
`define AXIS_SW_PARAMS_SVH

// stream field widths
`define AXIS_SW_DATA_WIDTH 32
`define AXIS_SW_USER_WIDTH 2
`define AXIS_SW_TID_WIDTH 2

// upstream masters: user project, axi-lite bridge, logic analyzer
`define AXIS_SW_NUM_SOURCES 3

// downstream FIFO sizing
`define AXIS_SW_FIFO_DEPTH 16
// ready drops once occupancy goes above this
`define AXIS_SW_FIFO_THRESHOLD 6

// downstream routing ids
`define AXIS_SW_TID_UP 0
`define AXIS_SW_TID_AA 1

`endif

// File: source/axis_sw_pkg.sv
`default_nettype none

`include "axis_sw_params.svh"

package axis_sw_pkg;

    typedef logic [`AXIS_SW_DATA_WIDTH-1:0] data_t;
    typedef logic [`AXIS_SW_USER_WIDTH-1:0] user_t;
    typedef logic [`AXIS_SW_TID_WIDTH-1:0] tid_t;

    // one bit per upstream source
    typedef logic [`AXIS_SW_NUM_SOURCES-1:0] grant_t;
    typedef logic [$clog2(`AXIS_SW_NUM_SOURCES)-1:0] src_idx_t;

    // extra msb tells full from empty
    typedef logic [$clog2(`AXIS_SW_FIFO_DEPTH):0] fifo_ptr_t;

    // packed as {data, last, tid, user}
    typedef logic [`AXIS_SW_DATA_WIDTH+1+`AXIS_SW_TID_WIDTH+`AXIS_SW_USER_WIDTH-1:0] fifo_entry_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_FRAME
    } arb_state_t;

endpackage

`default_nettype wire

// File: source/axis_upstream_arbiter.sv
`default_nettype none

`include "axis_sw_params.svh"

module axis_upstream_arbiter import axis_sw_pkg::*; (
    input  wire      axis_clk,
    input  wire      axi_reset_n,
    // source 0, user project
    input  wire data_t up_as_tdata,
    input  wire      up_as_tlast,
    input  wire user_t up_as_tuser,
    input  wire      up_as_tvalid,
    output logic     as_up_tready,
    // source 1, axi-lite bridge
    input  wire data_t aa_as_tdata,
    input  wire      aa_as_tlast,
    input  wire user_t aa_as_tuser,
    input  wire      aa_as_tvalid,
    output logic     as_aa_tready,
    // source 2, logic analyzer
    input  wire data_t la_as_tdata,
    input  wire      la_as_tlast,
    input  wire user_t la_as_tuser,
    input  wire      la_as_tvalid,
    output logic     as_la_tready,
    // serializer side
    output data_t    as_is_tdata,
    output logic     as_is_tlast,
    output user_t    as_is_tuser,
    output tid_t     as_is_tid,
    output logic     as_is_tvalid,
    input  wire      is_as_tready
);

    localparam int NUM_SRC = `AXIS_SW_NUM_SOURCES;

    arb_state_t state;
    grant_t     grant_reg;
    src_idx_t   rr_ptr;

    grant_t     req;
    src_idx_t   cand;
    src_idx_t   pick_idx;
    logic       pick_valid;
    src_idx_t   grant_idx;
    logic       in_frame;
    logic       sel_tvalid;
    logic       frame_done;

    function automatic src_idx_t wrap_inc(src_idx_t idx);
        return (idx == src_idx_t'(NUM_SRC - 1)) ? '0 : idx + src_idx_t'(1);
    endfunction

    function automatic src_idx_t grant_to_idx(grant_t g);
        src_idx_t idx;
        idx = '0;
        for (int n = 0; n < NUM_SRC; n++) begin
            if (g[n]) begin
                idx = src_idx_t'(n);
            end
        end
        return idx;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // round-robin pick, first request at or after the pointer
    //////////////////////////////////////////////////////////////////////

    assign req = {la_as_tvalid, aa_as_tvalid, up_as_tvalid};

    always_comb begin
        pick_valid = 1'b0;
        pick_idx   = rr_ptr;
        cand       = rr_ptr;
        for (int k = 0; k < NUM_SRC; k++) begin
            if (!pick_valid && req[cand]) begin
                pick_valid = 1'b1;
                pick_idx   = cand;
            end
            cand = wrap_inc(cand);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // granted source passes straight through during a frame
    //////////////////////////////////////////////////////////////////////

    assign in_frame  = (state == ARB_FRAME);
    assign grant_idx = grant_to_idx(grant_reg);

    always_comb begin
        as_is_tdata = up_as_tdata;
        as_is_tlast = up_as_tlast;
        as_is_tuser = up_as_tuser;
        sel_tvalid  = up_as_tvalid;
        case (grant_idx)
            src_idx_t'(1): begin
                as_is_tdata = aa_as_tdata;
                as_is_tlast = aa_as_tlast;
                as_is_tuser = aa_as_tuser;
                sel_tvalid  = aa_as_tvalid;
            end
            src_idx_t'(2): begin
                as_is_tdata = la_as_tdata;
                as_is_tlast = la_as_tlast;
                as_is_tuser = la_as_tuser;
                sel_tvalid  = la_as_tvalid;
            end
            default: ;
        endcase
    end

    assign as_is_tid    = tid_t'(grant_idx);
    assign as_is_tvalid = in_frame && sel_tvalid;

    // only the granted source sees the serializer ready
    assign as_up_tready = in_frame && grant_reg[0] && is_as_tready;
    assign as_aa_tready = in_frame && grant_reg[1] && is_as_tready;
    assign as_la_tready = in_frame && grant_reg[2] && is_as_tready;

    assign frame_done = as_is_tvalid && is_as_tready && as_is_tlast;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            state     <= ARB_IDLE;
            grant_reg <= '0;
            rr_ptr    <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_valid) begin
                        grant_reg <= grant_t'(1) << pick_idx;
                        state     <= ARB_FRAME;
                    end
                end
                ARB_FRAME: begin
                    // next frame search starts after the source just served
                    if (frame_done) begin
                        rr_ptr <= wrap_inc(grant_idx);
                        state  <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/axis_downstream_demux.sv
`default_nettype none

`include "axis_sw_params.svh"

module axis_downstream_demux import axis_sw_pkg::*; (
    input  wire        axis_clk,
    input  wire        axi_reset_n,
    // from the serializer
    input  wire data_t is_as_tdata,
    input  wire        is_as_tlast,
    input  wire user_t is_as_tuser,
    input  wire tid_t  is_as_tid,
    input  wire        is_as_tvalid,
    output logic       as_is_tready,
    // to the user project
    output data_t      as_up_tdata,
    output logic       as_up_tlast,
    output user_t      as_up_tuser,
    output logic       as_up_tvalid,
    input  wire        up_as_tready,
    // to the axi-lite bridge
    output data_t      as_aa_tdata,
    output logic       as_aa_tlast,
    output user_t      as_aa_tuser,
    output logic       as_aa_tvalid,
    input  wire        aa_as_tready
);

    localparam int DEPTH  = `AXIS_SW_FIFO_DEPTH;
    localparam int ADDR_W = $clog2(DEPTH);

    // field positions inside a stored entry
    localparam int USER_LSB = 0;
    localparam int TID_LSB  = USER_LSB + `AXIS_SW_USER_WIDTH;
    localparam int LAST_BIT = TID_LSB + `AXIS_SW_TID_WIDTH;
    localparam int DATA_LSB = LAST_BIT + 1;

    fifo_entry_t mem [DEPTH];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_ptr_t   occupancy;

    logic        wr_en;
    logic        not_empty;
    logic        pop;
    logic        discard;
    fifo_entry_t head;
    tid_t        head_tid;

    //////////////////////////////////////////////////////////////////////
    // write side with threshold flow control
    //////////////////////////////////////////////////////////////////////

    assign wr_en     = is_as_tvalid && as_is_tready;
    assign occupancy = wr_ptr - rd_ptr;

    always_ff @(posedge axis_clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= {is_as_tdata, is_as_tlast, is_as_tid, is_as_tuser};
        end
    end

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            wr_ptr       <= '0;
            as_is_tready <= 1'b0;
        end else begin
            // one cycle behind the occupancy, hence the two beats of slack
            as_is_tready <= (occupancy <= fifo_ptr_t'(`AXIS_SW_FIFO_THRESHOLD));
            if (wr_en) begin
                wr_ptr <= wr_ptr + fifo_ptr_t'(1);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // head decode and routing
    //////////////////////////////////////////////////////////////////////

    assign not_empty = (wr_ptr != rd_ptr);
    assign head      = mem[rd_ptr[ADDR_W-1:0]];
    assign head_tid  = head[TID_LSB +: `AXIS_SW_TID_WIDTH];

    assign as_up_tvalid = not_empty && (head_tid == tid_t'(`AXIS_SW_TID_UP));
    assign as_aa_tvalid = not_empty && (head_tid == tid_t'(`AXIS_SW_TID_AA));

    // unknown ids are dropped so they cannot block the FIFO
    assign discard = not_empty && !as_up_tvalid && !as_aa_tvalid;

    assign as_up_tdata = head[DATA_LSB +: `AXIS_SW_DATA_WIDTH];
    assign as_up_tlast = head[LAST_BIT];
    assign as_up_tuser = head[USER_LSB +: `AXIS_SW_USER_WIDTH];

    assign as_aa_tdata = head[DATA_LSB +: `AXIS_SW_DATA_WIDTH];
    assign as_aa_tlast = head[LAST_BIT];
    assign as_aa_tuser = head[USER_LSB +: `AXIS_SW_USER_WIDTH];

    assign pop = (as_up_tvalid && up_as_tready)
              || (as_aa_tvalid && aa_as_tready)
              || discard;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + fifo_ptr_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: source/axis_sw.sv
`default_nettype none

module axis_sw import axis_sw_pkg::*; (
    input  wire        axis_clk,
    input  wire        axi_reset_n,
    // upstream sources
    input  wire data_t up_as_tdata,
    input  wire        up_as_tlast,
    input  wire user_t up_as_tuser,
    input  wire        up_as_tvalid,
    output wire        as_up_tready,
    input  wire data_t aa_as_tdata,
    input  wire        aa_as_tlast,
    input  wire user_t aa_as_tuser,
    input  wire        aa_as_tvalid,
    output wire        as_aa_tready,
    input  wire data_t la_as_tdata,
    input  wire        la_as_tlast,
    input  wire user_t la_as_tuser,
    input  wire        la_as_tvalid,
    output wire        as_la_tready,
    // serializer, outbound
    output wire data_t as_is_tdata,
    output wire        as_is_tlast,
    output wire user_t as_is_tuser,
    output wire tid_t  as_is_tid,
    output wire        as_is_tvalid,
    input  wire        is_as_tready,
    // serializer, inbound
    input  wire data_t is_as_tdata,
    input  wire        is_as_tlast,
    input  wire user_t is_as_tuser,
    input  wire tid_t  is_as_tid,
    input  wire        is_as_tvalid,
    output wire        as_is_tready,
    // downstream destinations
    output wire data_t as_up_tdata,
    output wire        as_up_tlast,
    output wire user_t as_up_tuser,
    output wire        as_up_tvalid,
    input  wire        up_as_tready,
    output wire data_t as_aa_tdata,
    output wire        as_aa_tlast,
    output wire user_t as_aa_tuser,
    output wire        as_aa_tvalid,
    input  wire        aa_as_tready
);

    // 3 to 1 toward the serializer
    axis_upstream_arbiter upstream_inst (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .up_as_tdata  (up_as_tdata),
        .up_as_tlast  (up_as_tlast),
        .up_as_tuser  (up_as_tuser),
        .up_as_tvalid (up_as_tvalid),
        .as_up_tready (as_up_tready),
        .aa_as_tdata  (aa_as_tdata),
        .aa_as_tlast  (aa_as_tlast),
        .aa_as_tuser  (aa_as_tuser),
        .aa_as_tvalid (aa_as_tvalid),
        .as_aa_tready (as_aa_tready),
        .la_as_tdata  (la_as_tdata),
        .la_as_tlast  (la_as_tlast),
        .la_as_tuser  (la_as_tuser),
        .la_as_tvalid (la_as_tvalid),
        .as_la_tready (as_la_tready),
        .as_is_tdata  (as_is_tdata),
        .as_is_tlast  (as_is_tlast),
        .as_is_tuser  (as_is_tuser),
        .as_is_tid    (as_is_tid),
        .as_is_tvalid (as_is_tvalid),
        .is_as_tready (is_as_tready)
    );

    // 1 to 2 from the serializer
    axis_downstream_demux downstream_inst (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .is_as_tdata  (is_as_tdata),
        .is_as_tlast  (is_as_tlast),
        .is_as_tuser  (is_as_tuser),
        .is_as_tid    (is_as_tid),
        .is_as_tvalid (is_as_tvalid),
        .as_is_tready (as_is_tready),
        .as_up_tdata  (as_up_tdata),
        .as_up_tlast  (as_up_tlast),
        .as_up_tuser  (as_up_tuser),
        .as_up_tvalid (as_up_tvalid),
        .up_as_tready (up_as_tready),
        .as_aa_tdata  (as_aa_tdata),
        .as_aa_tlast  (as_aa_tlast),
        .as_aa_tuser  (as_aa_tuser),
        .as_aa_tvalid (as_aa_tvalid),
        .aa_as_tready (aa_as_tready)
    );

endmodule

`default_nettype wire

// File: test/axis_sw_assert.sv
`default_nettype none

module axis_sw_assert import axis_sw_pkg::*; (
    input wire       axis_clk,
    input wire       axi_reset_n,
    input wire       as_up_tvalid,
    input wire       as_aa_tvalid,
    input wire       as_is_tvalid,
    input wire       is_as_tready,
    input wire tid_t as_is_tid
);

    int fail_count = 0;

    // both outputs are fed from the single FIFO head
    one_output_valid: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        !(as_up_tvalid && as_aa_tvalid))
    else begin
        fail_count++;
        $error("as_up_tvalid and as_aa_tvalid high together");
    end

    // grant may not move while a beat is stalled
    tid_held_on_stall: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        (as_is_tvalid && !is_as_tready) |=> $stable(as_is_tid))
    else begin
        fail_count++;
        $error("as_is_tid changed while the serializer beat was stalled");
    end

    tid_in_range: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        as_is_tid != tid_t'(3))
    else begin
        fail_count++;
        $error("as_is_tid is 3");
    end

endmodule

`default_nettype wire

// File: test/axis_sw_tb.sv
`default_nettype none

`include "axis_sw_params.svh"

module axis_sw_tb import axis_sw_pkg::*; ();

    localparam int TIMEOUT   = 2000;
    localparam int MAX_BEATS = 256;
    localparam int THRESH    = `AXIS_SW_FIFO_THRESHOLD;

    // {last, user, data}
    typedef logic [`AXIS_SW_DATA_WIDTH+`AXIS_SW_USER_WIDTH:0] beat_t;

    logic axis_clk = 1'b0;
    logic axi_reset_n;

    // upstream sources, 0 up, 1 aa, 2 la
    data_t src_data  [3];
    logic  src_last  [3];
    user_t src_user  [3];
    logic  src_valid [3];
    logic  src_ready [3];

    data_t as_is_tdata;
    logic  as_is_tlast;
    user_t as_is_tuser;
    tid_t  as_is_tid;
    logic  as_is_tvalid;
    logic  is_as_tready = 1'b1;

    data_t is_as_tdata;
    logic  is_as_tlast;
    user_t is_as_tuser;
    tid_t  is_as_tid;
    logic  is_as_tvalid;
    logic  as_is_tready;

    data_t as_up_tdata;
    logic  as_up_tlast;
    user_t as_up_tuser;
    logic  as_up_tvalid;
    logic  up_as_tready = 1'b1;
    data_t as_aa_tdata;
    logic  as_aa_tlast;
    user_t as_aa_tuser;
    logic  as_aa_tvalid;
    logic  aa_as_tready = 1'b1;

    // expected beats per upstream source and per downstream output
    beat_t up_exp [3][MAX_BEATS];
    int    up_wr  [3];
    int    up_rd  [3] = '{0, 0, 0};
    beat_t dn_exp [2][MAX_BEATS];
    int    dn_wr  [2];
    int    dn_rd  [2] = '{0, 0};

    // arbiter model kept by the comparing process
    logic ref_busy  = 1'b0;
    int   ref_ptr   = 0;
    int   ref_grant = 0;

    logic up_rand_ready = 1'b0;
    int   dn_ready_mode = 0;

    int seq_errs   = 0;
    int seq_checks = 0;
    int mon_errs   = 0;
    int mon_checks = 0;
    int test_count = 0;
    int test_fail  = 0;

    event abort_ev;
    event never_ev;

    always #2 axis_clk = ~axis_clk;

    axis_sw axis_sw_inst (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .up_as_tdata  (src_data[0]),
        .up_as_tlast  (src_last[0]),
        .up_as_tuser  (src_user[0]),
        .up_as_tvalid (src_valid[0]),
        .as_up_tready (src_ready[0]),
        .aa_as_tdata  (src_data[1]),
        .aa_as_tlast  (src_last[1]),
        .aa_as_tuser  (src_user[1]),
        .aa_as_tvalid (src_valid[1]),
        .as_aa_tready (src_ready[1]),
        .la_as_tdata  (src_data[2]),
        .la_as_tlast  (src_last[2]),
        .la_as_tuser  (src_user[2]),
        .la_as_tvalid (src_valid[2]),
        .as_la_tready (src_ready[2]),
        .as_is_tdata  (as_is_tdata),
        .as_is_tlast  (as_is_tlast),
        .as_is_tuser  (as_is_tuser),
        .as_is_tid    (as_is_tid),
        .as_is_tvalid (as_is_tvalid),
        .is_as_tready (is_as_tready),
        .is_as_tdata  (is_as_tdata),
        .is_as_tlast  (is_as_tlast),
        .is_as_tuser  (is_as_tuser),
        .is_as_tid    (is_as_tid),
        .is_as_tvalid (is_as_tvalid),
        .as_is_tready (as_is_tready),
        .as_up_tdata  (as_up_tdata),
        .as_up_tlast  (as_up_tlast),
        .as_up_tuser  (as_up_tuser),
        .as_up_tvalid (as_up_tvalid),
        .up_as_tready (up_as_tready),
        .as_aa_tdata  (as_aa_tdata),
        .as_aa_tlast  (as_aa_tlast),
        .as_aa_tuser  (as_aa_tuser),
        .as_aa_tvalid (as_aa_tvalid),
        .aa_as_tready (aa_as_tready)
    );

    bind axis_sw axis_sw_assert assert_inst (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .as_up_tvalid (as_up_tvalid),
        .as_aa_tvalid (as_aa_tvalid),
        .as_is_tvalid (as_is_tvalid),
        .is_as_tready (is_as_tready),
        .as_is_tid    (as_is_tid)
    );

    //////////////////////////////////////////////////////////////////////
    // reference functions
    //////////////////////////////////////////////////////////////////////

    // first requester at or after ptr, -1 when nobody asks
    function automatic int expected_grant(input int ptr, input logic [2:0] req);
        int idx;
        expected_grant = -1;
        for (int k = 2; k >= 0; k--) begin
            idx = (ptr + k) % 3;
            if (req[idx]) begin
                expected_grant = idx;
            end
        end
    endfunction

    // 0 user project, 1 axi-lite bridge, 2 dropped
    function automatic int expected_dest(input int tid);
        if (tid == `AXIS_SW_TID_UP) begin
            return 0;
        end
        if (tid == `AXIS_SW_TID_AA) begin
            return 1;
        end
        return 2;
    endfunction

    task automatic print_err(input string msg);
        $display("ERR @%0t: %s", $time, msg);
    endtask

    task automatic fail_timeout(input string what);
        $display("gave up after %0d cycles waiting for %s", TIMEOUT, what);
        -> abort_ev;
        @(never_ev);
    endtask

    //////////////////////////////////////////////////////////////////////
    // comparing process, samples at the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic check_upstream_beat();
        beat_t got;
        got = {as_is_tlast, as_is_tuser, as_is_tdata};
        mon_checks++;
        if (int'(as_is_tid) != ref_grant) begin
            mon_errs++;
            print_err($sformatf("as_is_tid %0d, expected grant %0d", as_is_tid, ref_grant));
        end else if (is_as_tready) begin
            if (up_rd[ref_grant] >= up_wr[ref_grant]) begin
                mon_errs++;
                print_err($sformatf("extra beat from source %0d", ref_grant));
            end else begin
                if (got !== up_exp[ref_grant][up_rd[ref_grant] % MAX_BEATS]) begin
                    mon_errs++;
                    print_err($sformatf("source %0d beat %0d is %h, expected %h", ref_grant,
                        up_rd[ref_grant], got, up_exp[ref_grant][up_rd[ref_grant] % MAX_BEATS]));
                end
                up_rd[ref_grant]++;
            end
            if (as_is_tlast) begin
                ref_busy = 1'b0;
                ref_ptr  = (ref_grant + 1) % 3;
            end
        end
    endtask

    task automatic check_downstream_beat(input int d, input beat_t got);
        mon_checks++;
        if (dn_rd[d] >= dn_wr[d]) begin
            mon_errs++;
            print_err($sformatf("unexpected beat %h on output %0d", got, d));
        end else begin
            if (got !== dn_exp[d][dn_rd[d] % MAX_BEATS]) begin
                mon_errs++;
                print_err($sformatf("output %0d beat %0d is %h, expected %h", d, dn_rd[d],
                    got, dn_exp[d][dn_rd[d] % MAX_BEATS]));
            end
            dn_rd[d]++;
        end
    endtask

    always @(negedge axis_clk) begin : compare
        logic [2:0] req;
        int pick;
        if (!axi_reset_n) begin
            ref_busy = 1'b0;
            ref_ptr  = 0;
        end else begin
            req = {src_valid[2], src_valid[1], src_valid[0]};
            if (!ref_busy) begin
                mon_checks++;
                if (as_is_tvalid) begin
                    mon_errs++;
                    print_err("as_is_tvalid high while the arbiter should be idle");
                end
                // grant taken at the coming edge
                pick = expected_grant(ref_ptr, req);
                if (pick >= 0) begin
                    ref_grant = pick;
                    ref_busy  = 1'b1;
                end
            end else if (as_is_tvalid) begin
                check_upstream_beat();
            end
            if (as_up_tvalid && up_as_tready) begin
                check_downstream_beat(0, {as_up_tlast, as_up_tuser, as_up_tdata});
            end
            if (as_aa_tvalid && aa_as_tready) begin
                check_downstream_beat(1, {as_aa_tlast, as_aa_tuser, as_aa_tdata});
            end
        end
    end

    // ready patterns, mode picked up at the edge and applied just after
    always @(posedge axis_clk) begin : ready_patterns
        logic rand_up;
        int dn_mode;
        rand_up = up_rand_ready;
        dn_mode = dn_ready_mode;
        #1;
        is_as_tready = rand_up ? ($urandom % 2 == 0) : 1'b1;
        case (dn_mode)
            1: begin
                up_as_tready = ($urandom % 2 == 0);
                aa_as_tready = ($urandom % 3 != 0);
            end
            2: begin
                up_as_tready = 1'b0;
                aa_as_tready = 1'b0;
            end
            default: begin
                up_as_tready = 1'b1;
                aa_as_tready = 1'b1;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic drive_frames(input int s, input int nframes);
        int len;
        int n;
        logic fired;
        beat_t b;
        for (int f = 0; f < nframes; f++) begin
            len = 1 + int'($urandom % 4);
            for (int i = 0; i < len; i++) begin
                b = {(i == len - 1), user_t'($urandom), data_t'($urandom)};
                up_exp[s][up_wr[s] % MAX_BEATS] = b;
                up_wr[s]++;
                {src_last[s], src_user[s], src_data[s]} = b;
                src_valid[s] = 1'b1;
                n = 0;
                fired = 1'b0;
                while (!fired) begin
                    @(negedge axis_clk);
                    fired = src_ready[s];
                    @(posedge axis_clk);
                    #1;
                    n++;
                    if (!fired && n >= TIMEOUT) begin
                        fail_timeout($sformatf("tready of source %0d", s));
                    end
                end
            end
        end
        src_valid[s] = 1'b0;
    endtask

    // keeps a beat offered for ncycles, recording what the switch takes
    task automatic offer_downstream(input int ncycles, input int tid_mod, output int accepted);
        int d;
        logic fired;
        accepted = 0;
        fired = 1'b1;
        for (int c = 0; c < ncycles; c++) begin
            if (fired) begin
                is_as_tdata  = data_t'($urandom);
                is_as_tuser  = user_t'($urandom);
                is_as_tlast  = ($urandom % 3 == 0);
                is_as_tid    = tid_t'($urandom % tid_mod);
                is_as_tvalid = 1'b1;
            end
            @(negedge axis_clk);
            fired = as_is_tready;
            if (fired) begin
                d = expected_dest(int'(is_as_tid));
                if (d < 2) begin
                    dn_exp[d][dn_wr[d] % MAX_BEATS] = {is_as_tlast, is_as_tuser, is_as_tdata};
                    dn_wr[d]++;
                end
                accepted++;
            end
            @(posedge axis_clk);
            #1;
        end
        is_as_tvalid = 1'b0;
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (up_rd[0] != up_wr[0] || up_rd[1] != up_wr[1] || up_rd[2] != up_wr[2]
               || dn_rd[0] != dn_wr[0] || dn_rd[1] != dn_wr[1]) begin
            @(posedge axis_clk);
            #1;
            n++;
            if (n >= TIMEOUT) begin
                fail_timeout({"all beats of ", what, " to arrive"});
            end
        end
        repeat (2) begin
            @(posedge axis_clk);
        end
        #1;
    endtask

    task automatic check_quiet(input string when);
        seq_checks++;
        if (as_is_tvalid || as_up_tvalid || as_aa_tvalid || as_is_tready
            || src_ready[0] || src_ready[1] || src_ready[2]) begin
            seq_errs++;
            print_err({"outputs not all low ", when});
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        int errs;
        errs = seq_errs + mon_errs - errs_before;
        test_count++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            test_fail++;
            $display("test %s: %0d mismatches", name, errs);
        end
    endtask

    initial begin
        @(abort_ev);
        $display("ERRORS FOUND");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : main
        int errs_before;
        int accepted;
        int n;
        void'($urandom(32'hafed_3da3));
        axi_reset_n  = 1'b0;
        is_as_tdata  = '0;
        is_as_tlast  = 1'b0;
        is_as_tuser  = '0;
        is_as_tid    = '0;
        is_as_tvalid = 1'b0;
        for (int s = 0; s < 3; s++) begin
            src_data[s]  = '0;
            src_last[s]  = 1'b0;
            src_user[s]  = '0;
            src_valid[s] = 1'b0;
            up_wr[s]     = 0;
        end
        dn_wr[0] = 0;
        dn_wr[1] = 0;

        // reset
        errs_before = 0;
        repeat (4) begin
            @(negedge axis_clk);
            check_quiet("during reset");
        end
        @(posedge axis_clk);
        #1;
        axi_reset_n = 1'b1;
        @(negedge axis_clk);
        check_quiet("before the first edge after reset");
        n = 0;
        while (!as_is_tready) begin
            @(posedge axis_clk);
            #1;
            n++;
            if (n >= TIMEOUT) begin
                fail_timeout("as_is_tready to rise after reset");
            end
        end
        end_test("reset", errs_before);

        // one source at a time
        errs_before = seq_errs + mon_errs;
        for (int s = 0; s < 3; s++) begin
            drive_frames(s, 2);
            wait_drained($sformatf("source %0d", s));
        end
        end_test("single source", errs_before);

        // all sources busy, serializer ready toggling
        errs_before = seq_errs + mon_errs;
        up_rand_ready = 1'b1;
        fork
            drive_frames(0, 4);
            drive_frames(1, 4);
            drive_frames(2, 4);
        join
        wait_drained("round robin");
        up_rand_ready = 1'b0;
        end_test("round robin", errs_before);

        // every tid value, outputs stalling at random
        errs_before = seq_errs + mon_errs;
        dn_ready_mode = 1;
        offer_downstream(80, 4, accepted);
        wait_drained("routing");
        dn_ready_mode = 0;
        end_test("routing", errs_before);

        // both outputs stalled, FIFO must stop taking beats
        errs_before = seq_errs + mon_errs;
        dn_ready_mode = 2;
        @(posedge axis_clk);
        #1;
        offer_downstream(30, 2, accepted);
        seq_checks++;
        if (accepted > THRESH + 2 || accepted == 0) begin
            seq_errs++;
            print_err($sformatf("%0d beats accepted with outputs stalled, limit %0d",
                accepted, THRESH + 2));
        end
        dn_ready_mode = 0;
        wait_drained("threshold");
        end_test("threshold", errs_before);

        mon_errs += axis_sw_inst.assert_inst.fail_count;
        $display("tests %0d, failed %0d, checks %0d, mismatches %0d", test_count, test_fail,
            seq_checks + mon_checks, seq_errs + mon_errs);
        if (seq_errs + mon_errs == 0 && test_fail == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+source
source/axis_sw_pkg.sv
source/axis_upstream_arbiter.sv
source/axis_downstream_demux.sv
source/axis_sw.sv
test/axis_sw_assert.sv
test/axis_sw_tb.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         ?= axis_sw_tb
LOG         ?= sim.log
SEED_FLAGS  ?= +verilator+seed+1
RUN_FLAGS   ?= +verilator+error+limit+1000
FILELIST    ?= sim.f
BUILD_FLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SEED_FLAGS) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
